// ==== src/vmem_consts.svh ====
// Field widths and map depths of the virtual memory map, included by the package and RTL.
`ifndef VMEM_CONSTS_SVH
`define VMEM_CONSTS_SVH

// Virtual address fields, high to low.
`define VMEM_SECTION_BITS 5
`define VMEM_PAGE_BITS 10
`define VMEM_OFFSET_BITS 8

// Page map entry fields.
`define VMEM_FRAME_BITS 14
`define VMEM_STATUS_BITS 8
`define VMEM_ENTRY_BITS 24

// High frame bits held in a section entry.
`define VMEM_SECTION_FRAME_BITS 4

// Map depths.
`define VMEM_SECTION_DEPTH (1 << `VMEM_SECTION_BITS)
`define VMEM_PAGE_DEPTH (1 << `VMEM_PAGE_BITS)

`endif

// ==== src/vmem_pkg.sv ====
// Types shared by the address translation RTL; import into a module body where used.
`default_nettype none

`include "vmem_consts.svh"

package vmem_pkg;

   typedef logic [`VMEM_SECTION_BITS-1:0] section_index_t;
   typedef logic [`VMEM_PAGE_BITS-1:0] page_index_t;
   typedef logic [`VMEM_OFFSET_BITS-1:0] offset_t;
   typedef logic [`VMEM_FRAME_BITS-1:0] frame_t;
   typedef logic [`VMEM_SECTION_FRAME_BITS-1:0] section_frame_t;
   typedef logic [`VMEM_STATUS_BITS-1:0] status_t;

   // Whatever the entry leaves after frame and status is the access code.
   typedef logic [`VMEM_ENTRY_BITS-`VMEM_FRAME_BITS-`VMEM_STATUS_BITS-1:0] access_t;

   typedef enum logic [1:0]
   {
      fault_none,
      fault_section,
      fault_page,
      fault_write
   } fault_t;

   typedef struct packed
   {
      section_index_t section;
      page_index_t page;
      offset_t offset;
   } vaddr_t;

   typedef struct packed
   {
      section_frame_t section_frame;
      frame_t page_frame;
      offset_t offset;
   } paddr_t;

   typedef struct packed
   {
      status_t status;
      access_t access;
      frame_t frame;
   } page_entry_t;

   typedef struct packed
   {
      logic valid;
      section_frame_t frame_hi;
   } section_entry_t;

   typedef struct packed
   {
      vaddr_t vaddr;
      logic write;
   } xlate_req_t;

   typedef struct packed
   {
      paddr_t paddr;
      status_t status;
      fault_t fault;
   } xlate_rsp_t;

   // A section load uses only the low bits of index and entry.
   typedef struct packed
   {
      logic to_section;
      page_index_t index;
      page_entry_t entry;
   } map_load_t;

endpackage

`default_nettype wire

// ==== src/map_ram.sv ====
// Page map RAM with a registered lookup read port and a load write port on one clock.
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module map_ram
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  rd_en,
   input  vmem_pkg::page_index_t rd_index,
   output vmem_pkg::page_entry_t rd_entry,
   input  logic                  wr_en,
   input  vmem_pkg::page_index_t wr_index,
   input  vmem_pkg::page_entry_t wr_entry
);

   import vmem_pkg::*;

   localparam int depth = `VMEM_PAGE_DEPTH;

   logic [`VMEM_ENTRY_BITS-1:0] ram [0:depth-1];
   page_entry_t rd_q;

   always_ff @(posedge clk_a)
   begin
      if (wr_en)
      begin
         ram[wr_index] <= wr_entry;
      end
   end

   // Read sees the old contents when the same index is written in this cycle.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_q <= '0;
      end
      else if (rd_en)
      begin
         rd_q <= page_entry_t'(ram[rd_index]);
      end
   end

   assign rd_entry = rd_q;

   // A load must present a known index and entry.
   a_wr_known : assert property (
      @(posedge clk_a) disable iff (reset)
      wr_en |-> !$isunknown({wr_index, wr_entry})
   );

endmodule

`default_nettype wire

// ==== src/section_map.sv ====
// Section map register file with a registered read matching the page map latency.
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module section_map
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     rd_en,
   input  vmem_pkg::section_index_t rd_index,
   output vmem_pkg::section_entry_t rd_entry,
   input  logic                     wr_en,
   input  vmem_pkg::section_index_t wr_index,
   input  vmem_pkg::section_entry_t wr_entry
);

   import vmem_pkg::*;

   localparam int depth = `VMEM_SECTION_DEPTH;

   logic [depth-1:0] valid;
   section_frame_t frame_hi [0:depth-1];
   section_entry_t rd_q;

   // Untouched sections stay invalid and fault.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         valid <= '0;
      end
      else if (wr_en)
      begin
         valid[wr_index] <= wr_entry.valid;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (wr_en)
      begin
         frame_hi[wr_index] <= wr_entry.frame_hi;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_q <= '0;
      end
      else if (rd_en)
      begin
         rd_q.valid <= valid[rd_index];
         rd_q.frame_hi <= frame_hi[rd_index];
      end
   end

   assign rd_entry = rd_q;

   // Arbitration upstream keeps lookups and loads apart.
   a_no_rd_wr : assert property (
      @(posedge clk_a) disable iff (reset)
      !(rd_en && wr_en)
   );

endmodule

`default_nettype wire

// ==== src/xlate_combine.sv ====
// Request and load arbitration, lookup merge and the two-entry response buffer.
`timescale 1ns/1ps
`default_nettype none

module xlate_combine
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     req_valid,
   input  vmem_pkg::xlate_req_t     req,
   output logic                     req_ready,
   input  logic                     load_valid,
   input  vmem_pkg::map_load_t      load,
   output logic                     load_ready,
   output logic                     lookup_en,
   output logic                     page_wren,
   output logic                     section_wren,
   input  vmem_pkg::page_entry_t    page_entry,
   input  vmem_pkg::section_entry_t section_entry,
   output logic                     rsp_valid,
   output vmem_pkg::xlate_rsp_t     rsp,
   input  logic                     rsp_ready
);

   import vmem_pkg::*;

   logic inflight;
   offset_t pend_offset;
   logic pend_write;

   xlate_rsp_t merged;
   xlate_rsp_t rsp_buf [0:1];
   logic wr_ptr;
   logic rd_ptr;
   logic [1:0] count;

   logic rsp_fire;
   logic load_fire;

   assign rsp_fire = rsp_valid && rsp_ready;

   // One slot per in-flight lookup or buffered response; a pop frees one.
   assign req_ready = ((2'(inflight) + count) < 2'd2) || rsp_fire;
   assign lookup_en = req_valid && req_ready;

   // Lookups win; a load waits for a cycle with no accepted request.
   assign load_ready = !lookup_en;
   assign load_fire = load_valid && load_ready;
   assign page_wren = load_fire && !load.to_section;
   assign section_wren = load_fire && load.to_section;

   always_ff @(posedge clk_a)
   begin
      if (lookup_en)
      begin
         pend_offset <= req.vaddr.offset;
         pend_write <= req.write;
      end
   end

   always_comb
   begin
      merged.paddr.section_frame = section_entry.frame_hi;
      merged.paddr.page_frame = page_entry.frame;
      merged.paddr.offset = pend_offset;
      merged.status = page_entry.status;
      // Access 00 is no access, 01 read only, 1x read and write.
      if (!section_entry.valid)
         merged.fault = fault_section;
      else if (page_entry.access == 2'b00)
         merged.fault = fault_page;
      else if (pend_write && page_entry.access == 2'b01)
         merged.fault = fault_write;
      else
         merged.fault = fault_none;
   end

   always_ff @(posedge clk_a)
   begin
      if (inflight)
      begin
         rsp_buf[wr_ptr] <= merged;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         inflight <= 1'b0;
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count <= 2'd0;
      end
      else
      begin
         inflight <= lookup_en;
         if (inflight)
            wr_ptr <= !wr_ptr;
         if (rsp_fire)
            rd_ptr <= !rd_ptr;
         count <= count + 2'(inflight) - 2'(rsp_fire);
      end
   end

   assign rsp_valid = (count != 2'd0);
   assign rsp = rsp_buf[rd_ptr];

   // A returning lookup always finds room.
   a_no_overflow : assert property (
      @(posedge clk_a) disable iff (reset)
      inflight |-> (count < 2'd2 || rsp_fire)
   );

   a_rsp_stable : assert property (
      @(posedge clk_a) disable iff (reset)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
   );

endmodule

`default_nettype wire

// ==== src/vmem_xlate.sv ====
// Top level of the two-level virtual memory map with request, load and response channels.
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module vmem_xlate
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  logic                 req_valid,
   input  vmem_pkg::xlate_req_t req,
   output logic                 req_ready,
   input  logic                 load_valid,
   input  vmem_pkg::map_load_t  load,
   output logic                 load_ready,
   output logic                 rsp_valid,
   output vmem_pkg::xlate_rsp_t rsp,
   input  logic                 rsp_ready
);

   import vmem_pkg::*;

   logic lookup_en;
   logic page_wren;
   logic section_wren;
   page_entry_t page_entry;
   section_entry_t section_entry;

   // Both maps are addressed straight from the request and load payloads.
   map_ram map_ram_i
   (
      .clk_a    (clk_a),
      .reset    (reset),
      .rd_en    (lookup_en),
      .rd_index (req.vaddr.page),
      .rd_entry (page_entry),
      .wr_en    (page_wren),
      .wr_index (load.index),
      .wr_entry (load.entry)
   );

   section_map section_map_i
   (
      .clk_a    (clk_a),
      .reset    (reset),
      .rd_en    (lookup_en),
      .rd_index (req.vaddr.section),
      .rd_entry (section_entry),
      .wr_en    (section_wren),
      .wr_index (load.index[`VMEM_SECTION_BITS-1:0]),
      .wr_entry (section_entry_t'(load.entry[`VMEM_SECTION_FRAME_BITS:0]))
   );

   xlate_combine xlate_combine_i
   (
      .clk_a         (clk_a),
      .reset         (reset),
      .req_valid     (req_valid),
      .req           (req),
      .req_ready     (req_ready),
      .load_valid    (load_valid),
      .load          (load),
      .load_ready    (load_ready),
      .lookup_en     (lookup_en),
      .page_wren     (page_wren),
      .section_wren  (section_wren),
      .page_entry    (page_entry),
      .section_entry (section_entry),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp),
      .rsp_ready     (rsp_ready)
   );

endmodule

`default_nettype wire

// ==== bench/vmem_xlate_tb.sv ====
// Testbench for the virtual memory map top level; compile with tb.f and run vmem_xlate_tb.
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module vmem_xlate_tb;

   import vmem_pkg::*;

   typedef struct packed
   {
      logic full;
      xlate_rsp_t rsp;
   } expect_t;

   localparam int n_stream = 200;
   localparam int n_mixed_req = 150;
   localparam int n_mixed_load = 60;
   localparam int n_ops = 4 + 32 + 7 + n_stream + n_mixed_req + n_mixed_load;

   logic clk_a;
   logic reset;
   logic req_valid;
   xlate_req_t req;
   logic req_ready;
   logic load_valid;
   map_load_t load;
   logic load_ready;
   logic rsp_valid;
   xlate_rsp_t rsp;
   logic rsp_ready;

   section_entry_t sec_shadow [0:`VMEM_SECTION_DEPTH-1];
   bit sec_loaded [0:`VMEM_SECTION_DEPTH-1];
   page_entry_t page_shadow [0:`VMEM_PAGE_DEPTH-1];
   bit page_loaded [0:`VMEM_PAGE_DEPTH-1];
   expect_t expect_q [$];
   expect_t popped;
   bit stall_seen;
   xlate_rsp_t stall_rsp;
   bit stream_done;

   vmem_xlate vmem_xlate_i
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .load_valid (load_valid),
      .load       (load),
      .load_ready (load_ready),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_ready  (rsp_ready)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #10 clk_a = ~clk_a;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (actual !== expected)
      begin
         stop_with_failure($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
      end
   endtask

   // Expected response from the shadow maps; fields from unloaded entries are not compared.
   function automatic expect_t expect_xlate(input xlate_req_t r);
      expect_t e;
      section_entry_t s;
      page_entry_t p;
      s = sec_shadow[r.vaddr.section];
      p = page_shadow[r.vaddr.page];
      e.full = sec_loaded[r.vaddr.section] && page_loaded[r.vaddr.page];
      e.rsp.paddr = {s.frame_hi, p.frame, r.vaddr.offset};
      e.rsp.status = p.status;
      if (!s.valid)
         e.rsp.fault = fault_section;
      else if (p.access == 2'b00)
         e.rsp.fault = fault_page;
      else if (r.write && p.access == 2'b01)
         e.rsp.fault = fault_write;
      else
         e.rsp.fault = fault_none;
      return e;
   endfunction

   function automatic xlate_req_t make_req(input int section, input int page, input logic wr);
      xlate_req_t r;
      r.vaddr.section = section_index_t'(section);
      r.vaddr.page = page_index_t'(page);
      r.vaddr.offset = offset_t'($urandom);
      r.write = wr;
      return r;
   endfunction

   function automatic map_load_t page_load(input int idx, input access_t acc);
      map_load_t l;
      l.to_section = 1'b0;
      l.index = page_index_t'(idx);
      l.entry.status = status_t'($urandom);
      l.entry.access = acc;
      l.entry.frame = frame_t'($urandom);
      return l;
   endfunction

   function automatic map_load_t section_load(input int idx, input logic valid);
      map_load_t l;
      l = '0;
      l.to_section = 1'b1;
      l.index = page_index_t'(idx);
      l.entry[`VMEM_SECTION_FRAME_BITS:0] = {valid, section_frame_t'($urandom)};
      return l;
   endfunction

   // Mostly the access 10 pages, now and then the no access and read only ones.
   function automatic int pick_page();
      if ($urandom % 4 == 0)
         return 20 + int'($urandom % 2);
      return int'($urandom % 16);
   endfunction

   // Called right after a rising edge; returns at the edge that accepts.
   task automatic send_req(input xlate_req_t r);
      req_valid <= 1'b1;
      req <= r;
      do @(posedge clk_a); while (!req_ready);
      req_valid <= 1'b0;
   endtask

   task automatic send_load(input map_load_t l);
      load_valid <= 1'b1;
      load <= l;
      do @(posedge clk_a); while (!load_ready);
      load_valid <= 1'b0;
   endtask

   // With the buffer empty the response is valid only after the edge following acceptance.
   task automatic send_req_timed(input xlate_req_t r);
      send_req(r);
      @(posedge clk_a);
      check("rsp_valid", 64'(1'b0), 64'(rsp_valid));
      @(posedge clk_a);
      check("rsp_valid", 64'(1'b1), 64'(rsp_valid));
   endtask

   task automatic toggle_ready();
      while (!stream_done)
      begin
         rsp_ready <= 1'($urandom);
         @(posedge clk_a);
      end
      rsp_ready <= 1'b1;
   endtask

   always @(posedge clk_a)
   begin
      if (reset)
      begin
         for (int i = 0; i < `VMEM_SECTION_DEPTH; i++)
         begin
            sec_shadow[i] = '0;
            sec_loaded[i] = 1'b0;
         end
         for (int i = 0; i < `VMEM_PAGE_DEPTH; i++)
         begin
            page_shadow[i] = '0;
            page_loaded[i] = 1'b0;
         end
         stall_seen = 1'b0;
      end
      else
      begin
         if (stall_seen)
         begin
            check("rsp_valid", 64'(1'b1), 64'(rsp_valid));
            check("rsp", 64'(stall_rsp), 64'(rsp));
         end
         stall_seen = rsp_valid && !rsp_ready;
         stall_rsp = rsp;
         if (rsp_valid && rsp_ready)
         begin
            if (expect_q.size() == 0)
               stop_with_failure("A response came out with no request outstanding.");
            else
            begin
               popped = expect_q.pop_front();
               if (popped.full)
                  check("rsp", 64'(popped.rsp), 64'(rsp));
               else
                  check("rsp.fault", 64'(popped.rsp.fault), 64'(rsp.fault));
            end
         end
         if (load_valid && load_ready)
         begin
            if (load.to_section)
            begin
               sec_shadow[load.index[`VMEM_SECTION_BITS-1:0]] =
                  section_entry_t'(load.entry[`VMEM_SECTION_FRAME_BITS:0]);
               sec_loaded[load.index[`VMEM_SECTION_BITS-1:0]] = 1'b1;
            end
            else
            begin
               page_shadow[load.index] = load.entry;
               page_loaded[load.index] = 1'b1;
            end
         end
         if (req_valid && req_ready)
         begin
            check("load_ready", 64'(1'b0), 64'(load_ready));
            expect_q.push_back(expect_xlate(req));
         end
      end
   end

   initial
   begin
      repeat (n_ops * 20) @(posedge clk_a);
      stop_with_failure("Timeout: the tests did not finish in the allowed number of cycles.");
   end

   initial
   begin
      void'($urandom(24));
      reset = 1'b1;
      req_valid = 1'b0;
      req = '0;
      load_valid = 1'b0;
      load = '0;
      rsp_ready = 1'b1;
      stream_done = 1'b0;
      repeat (4) @(posedge clk_a);
      reset <= 1'b0;
      @(posedge clk_a);
      check("req_ready", 64'(1'b1), 64'(req_ready));
      check("load_ready", 64'(1'b1), 64'(load_ready));
      check("rsp_valid", 64'(1'b0), 64'(rsp_valid));

      // Every section is invalid after reset.
      for (int i = 0; i < 4; i++)
         send_req_timed(make_req(i * 8 + 3, i, 1'(i)));

      for (int i = 0; i < 8; i++)
         send_load(section_load(i, 1'b1));
      for (int i = 0; i < 16; i++)
         send_load(page_load(i, 2'b10));
      for (int i = 0; i < 8; i++)
         send_req_timed(make_req(i, i * 2, 1'(i)));

      send_load(page_load(20, 2'b00));
      send_load(page_load(21, 2'b01));
      send_load(section_load(9, 1'b0));
      send_req_timed(make_req(1, 20, 1'b0));
      send_req_timed(make_req(1, 21, 1'b0));
      send_req_timed(make_req(1, 21, 1'b1));
      send_req_timed(make_req(9, 20, 1'b0));

      // Back-to-back stream under random back-pressure.
      fork
         begin
            for (int i = 0; i < n_stream; i++)
               send_req(make_req(int'($urandom % 10), pick_page(), 1'($urandom)));
            stream_done = 1'b1;
         end
         toggle_ready();
      join

      // Loads compete with requests and reload pages that are being looked up.
      stream_done = 1'b0;
      fork
         begin
            for (int i = 0; i < n_mixed_req; i++)
            begin
               if ($urandom % 3 == 0)
                  @(posedge clk_a);
               send_req(make_req(int'($urandom % 8), int'($urandom % 16), 1'($urandom)));
            end
            stream_done = 1'b1;
         end
         begin
            for (int i = 0; i < n_mixed_load; i++)
            begin
               if ($urandom % 4 == 0)
                  send_load(section_load(int'($urandom % 8), 1'($urandom)));
               else
                  send_load(page_load(int'($urandom % 16), access_t'($urandom)));
            end
         end
         toggle_ready();
      join

      rsp_ready <= 1'b1;
      repeat (8) @(posedge clk_a);
      check("rsp_valid", 64'(1'b0), 64'(rsp_valid));
      if (expect_q.size() != 0)
         stop_with_failure("Some accepted requests never got a response.");
      else
      begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/vmem_pkg.sv
src/map_ram.sv
src/section_map.sv
src/xlate_combine.sv
src/vmem_xlate.sv
bench/vmem_xlate_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f tb.f --top-module vmem_xlate_tb \
		-Mdir $(OBJ_DIR) -o vmem_xlate_tb
	./$(OBJ_DIR)/vmem_xlate_tb

clean:
	rm -rf $(OBJ_DIR)
